/* loadStoreUnit.f */
hdl/lsuPkg.sv
hdl/lsuAddressDecode.sv
hdl/fixedMemory.sv
hdl/ioRegisterBank.sv
hdl/directMappedCache.sv
hdl/lsuResultWriteback.sv
hdl/loadStoreUnit.sv
verif/tbLoadStoreUnit.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tbLoadStoreUnit
FILELIST  = loadStoreUnit.f
BUILDDIR  = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

/* verif/tbLoadStoreUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module tbLoadStoreUnit
    import lsuPkg::*;
();

    localparam int ClkPeriod  = 8;
    localparam int Seed       = 66213;
    localparam int NumOps     = 400;
    localparam int SweepCount = 16;
    localparam int TimeoutNs  = (NumOps + SweepCount) * 60 * ClkPeriod + 10 * ClkPeriod;

    logic    clk = 1'b0;
    logic    clkEn;
    logic    rstN;
    logic    req;
    minorOp  op;
    dataWord addr;
    dataWord storeData;
    regAddr  destReg;
    logic    ack;
    logic    error;
    dataWord loadData;
    logic    wbValid;
    regAddr  wbReg;
    dataWord wbData;
    dataWord ioPins;
    logic    memReq;
    logic    memAck;
    logic    memWrite;
    dataWord memAddr;
    dataWord memWdata;
    dataWord memRdata;

    int stimSeed   = Seed;
    int enableSeed = Seed;
    int delaySeed  = Seed;

    // reference model
    dataWord                  modelFixed [FixedDepth];
    logic                     fixedKnown [FixedDepth];
    dataWord                  modelIo [IoRegCount];
    dataWord                  modelBacking [dataWord];
    logic                     lineValid [CacheLines];
    logic [CacheTagWidth-1:0] lineTag [CacheLines];
    dataWord                  fixedPool [SweepCount];

    // responder side
    dataWord memStore [dataWord];
    logic    seenWrite [$];
    dataWord seenAddr [$];
    dataWord seenData [$];

    // monitor side
    int      wbTotal = 0;
    int      ackTotal = 0;
    regAddr  lastWbReg;
    dataWord lastWbData;
    logic    lastAck = 1'b0;
    logic    lastReq = 1'b0;
    logic    lastEn = 1'b0;
    logic    lastRstN = 1'b0;
    logic    lastWbValid = 1'b0;
    logic    lastMemReq = 1'b0;

    int dataErrors = 0;
    int protocolErrors = 0;
    int opCount = 0;

    loadStoreUnit u_loadStoreUnit (.*);

    always #(ClkPeriod / 2) clk = ~clk;

    function automatic int drawBelow(inout int s, input int n);
        int r;
        r = $random(s);
        if (r < 0) r = -(r + 1);
        return r % n;
    endfunction

    // unwritten backing words hold a value derived from the full address
    function automatic dataWord fillPattern(input dataWord a);
        return {a[7:0], a[15:8]} ^ 16'h3c5a ^ (a << 3);
    endfunction

    function automatic dataWord backingValue(input dataWord a);
        if (modelBacking.exists(a)) return modelBacking[a];
        return fillPattern(a);
    endfunction

    function automatic dataWord storedWord(input dataWord a);
        if (memStore.exists(a)) return memStore[a];
        return fillPattern(a);
    endfunction

    function automatic dataWord randomFixedAddress();
        int r;
        r = drawBelow(stimSeed, 896);
        if (r >= 384) r = r + 128; // skip over the IO window
        return dataWord'(r);
    endfunction

    function automatic dataWord pickAddress(input int region);
        int a;
        int b;
        if (region == 0) begin
            if (drawBelow(stimSeed, 4) != 0) return fixedPool[drawBelow(stimSeed, SweepCount)];
            return randomFixedAddress();
        end else if (region == 1) begin
            return IoBase + dataWord'(drawBelow(stimSeed, 128));
        end
        // a few tags over a few lines so that hits and conflicts both happen
        if (drawBelow(stimSeed, 8) != 0) begin
            a = drawBelow(stimSeed, 3);
            b = drawBelow(stimSeed, 4);
            return CacheBase + dataWord'(a * 256 + b);
        end
        return CacheBase + dataWord'(drawBelow(stimSeed, 65536 - 1024));
    endfunction

    task automatic reportMismatch(input string name, input dataWord expected, input dataWord actual);
        dataErrors++;
        $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic reportFailure(input string what);
        dataErrors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic reportProtocol(input string what);
        protocolErrors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    // ********************
    // one operation
    // ********************
    task automatic runOperation(input minorOp opIn, input dataWord a, input dataWord d,
                                input regAddr rg);
        logic    valid;
        logic    expWb;
        logic    knownOld;
        logic    hit;
        dataWord expOld;
        int      wbBefore;
        int      ackBefore;
        int      txBefore;
        int      txCount;
        logic    expWrite [$];
        dataWord expAddr [$];
        dataWord expData [$];

        valid    = (opIn == OpLoad) || (opIn == OpStore) || (opIn == OpSwap);
        expWb    = valid && (opIn != OpStore);
        expOld   = '0;
        knownOld = 1'b0;
        if (valid && a >= CacheBase) begin
            hit = lineValid[a[CacheIndexWidth-1:0]] &&
                  (lineTag[a[CacheIndexWidth-1:0]] == a[DataWidth-1:CacheIndexWidth]);
            expOld   = backingValue(a);
            knownOld = 1'b1;
            if (opIn != OpStore && !hit) begin // fill on load or swap miss
                expWrite.push_back(1'b0);
                expAddr.push_back(a);
                expData.push_back('0);
                lineValid[a[CacheIndexWidth-1:0]] = 1'b1;
                lineTag[a[CacheIndexWidth-1:0]]   = a[DataWidth-1:CacheIndexWidth];
            end
            if (opIn != OpLoad) begin
                expWrite.push_back(1'b1);
                expAddr.push_back(a);
                expData.push_back(d);
                modelBacking[a] = d;
            end
        end else if (valid && a >= IoBase && a <= IoLimit) begin
            expOld   = modelIo[a[IoIndexWidth-1:0]];
            knownOld = 1'b1;
            if (opIn != OpLoad) modelIo[a[IoIndexWidth-1:0]] = d;
        end else if (valid) begin
            expOld   = modelFixed[a[FixedIndexWidth-1:0]];
            knownOld = fixedKnown[a[FixedIndexWidth-1:0]];
            if (opIn != OpLoad) begin
                modelFixed[a[FixedIndexWidth-1:0]] = d;
                fixedKnown[a[FixedIndexWidth-1:0]] = 1'b1;
            end
        end

        @(negedge clk);
        wbBefore  = wbTotal;
        ackBefore = ackTotal;
        txBefore  = seenAddr.size();
        if (ack) reportFailure("ack still high when a new request starts");
        req       = 1'b1;
        op        = opIn;
        addr      = a;
        storeData = d;
        destReg   = rg;
        while (!ack) @(negedge clk);

        if (error !== !valid) reportMismatch("error", dataWord'(!valid), dataWord'(error));
        if (expWb && knownOld && loadData !== expOld) reportMismatch("loadData", expOld, loadData);
        req = 1'b0;
        while (ack) @(negedge clk);

        if (wbTotal - wbBefore != (expWb ? 1 : 0)) begin
            reportFailure($sformatf("wbValid pulsed %0d times for opcode %0d",
                                    wbTotal - wbBefore, opIn));
        end else if (expWb) begin
            if (lastWbReg !== rg) reportMismatch("wbReg", dataWord'(rg), dataWord'(lastWbReg));
            if (knownOld && lastWbData !== expOld) reportMismatch("wbData", expOld, lastWbData);
        end
        if (ackTotal - ackBefore != 1) begin
            reportFailure($sformatf("ack rose %0d times for one request", ackTotal - ackBefore));
        end

        txCount = seenAddr.size() - txBefore;
        if (txCount != expAddr.size()) begin
            reportFailure($sformatf("%0d backing transactions for address %h, expected %0d",
                                    txCount, a, expAddr.size()));
        end else begin
            for (int i = 0; i < txCount; i++) begin
                if (seenWrite[txBefore + i] !== expWrite[i]) begin
                    reportMismatch("memWrite", dataWord'(expWrite[i]),
                                   dataWord'(seenWrite[txBefore + i]));
                end
                if (seenAddr[txBefore + i] !== expAddr[i]) begin
                    reportMismatch("memAddr", expAddr[i], seenAddr[txBefore + i]);
                end
                if (expWrite[i] && seenData[txBefore + i] !== expData[i]) begin
                    reportMismatch("memWdata", expData[i], seenData[txBefore + i]);
                end
            end
        end
        if (ioPins !== modelIo[0]) reportMismatch("ioPins", modelIo[0], ioPins);
        opCount++;
    endtask

    // ********************
    // backing memory
    // ********************
    initial begin
        int delay;
        memAck   = 1'b0;
        memRdata = '0;
        forever begin
            @(negedge clk);
            if (memReq === 1'b1) begin
                delay = drawBelow(delaySeed, 6);
                repeat (delay) @(negedge clk);
                seenWrite.push_back(memWrite);
                seenAddr.push_back(memAddr);
                seenData.push_back(memWdata);
                if (memWrite) begin
                    memStore[memAddr] = memWdata;
                end else begin
                    memRdata = storedWord(memAddr);
                end
                memAck = 1'b1;
                while (memReq) @(negedge clk);
                memAck = 1'b0;
            end
        end
    end

    initial begin
        clkEn = 1'b1;
        repeat (8) @(negedge clk);
        forever begin
            @(negedge clk);
            clkEn = drawBelow(enableSeed, 4) != 0; // low on about one edge in four
        end
    end

    // values are taken before the edge updates them
    always @(posedge clk) begin
        if (rstN && lastRstN) begin
            if (ack && !lastAck) begin
                ackTotal++;
                if (!lastReq) reportProtocol("ack rose while req was low");
            end
            if (lastAck && lastReq && !ack) reportProtocol("ack fell while req was still high");
            if (!lastEn && (ack !== lastAck || wbValid !== lastWbValid || memReq !== lastMemReq)) begin
                reportProtocol("ack, wbValid or memReq changed on an edge with clkEn low");
            end
            if (clkEn && wbValid) begin
                wbTotal++;
                lastWbReg  = wbReg;
                lastWbData = wbData;
            end
        end
        lastAck     = ack;
        lastReq     = req;
        lastEn      = clkEn;
        lastRstN    = rstN;
        lastWbValid = wbValid;
        lastMemReq  = memReq;
    end

    initial begin
        #(TimeoutNs);
        $display("Error at %0t ns: watchdog expired before all operations completed", $time);
        $display("** FAIL **");
        $finish;
    end

    // ********************
    // main sequence
    // ********************
    initial begin
        int      opPick;
        minorOp  opNext;
        dataWord addrNext;
        dataWord dataNext;
        regAddr  regNext;
        int      region;
        rstN      = 1'b0;
        req       = 1'b0;
        op        = OpLoad;
        addr      = '0;
        storeData = '0;
        destReg   = '0;
        for (int i = 0; i < FixedDepth; i++) fixedKnown[i] = 1'b0;
        for (int i = 0; i < IoRegCount; i++) modelIo[i] = '0;
        for (int i = 0; i < CacheLines; i++) lineValid[i] = 1'b0;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        if (wbValid !== 1'b0) reportMismatch("wbValid", '0, dataWord'(wbValid));
        if (memReq !== 1'b0) reportMismatch("memReq", '0, dataWord'(memReq));
        if (ack !== 1'b0) reportMismatch("ack", '0, dataWord'(ack));

        // give the fixed pool known contents first
        for (int i = 0; i < SweepCount; i++) begin
            fixedPool[i] = randomFixedAddress();
            dataNext     = dataWord'(drawBelow(stimSeed, 65536));
            runOperation(OpStore, fixedPool[i], dataNext, '0);
        end

        for (int n = 0; n < NumOps; n++) begin
            opPick = drawBelow(stimSeed, 8);
            if (opPick < 3) begin
                opNext = OpLoad;
            end else if (opPick < 5) begin
                opNext = OpStore;
            end else if (opPick < 7) begin
                opNext = OpSwap;
            end else begin
                opNext = minorOp'(3 + drawBelow(stimSeed, 13)); // outside the valid set
            end
            region   = drawBelow(stimSeed, 3);
            addrNext = pickAddress(region);
            dataNext = dataWord'(drawBelow(stimSeed, 65536));
            regNext  = regAddr'(drawBelow(stimSeed, 16));
            runOperation(opNext, addrNext, dataNext, regNext);
        end

        repeat (4) @(negedge clk);
        $display("operations %0d, data errors %0d, protocol errors %0d",
                 opCount, dataErrors, protocolErrors);
        if (dataErrors == 0 && protocolErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/loadStoreUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module loadStoreUnit
    import lsuPkg::*;
(
    input  logic    clk,
    input  logic    clkEn,
    input  logic    rstN,
    input  logic    req,
    input  minorOp  op,
    input  dataWord addr,
    input  dataWord storeData,
    input  regAddr  destReg,
    output logic    ack,
    output logic    error,
    output dataWord loadData,
    output logic    wbValid,
    output regAddr  wbReg,
    output dataWord wbData,
    output dataWord ioPins,
    output logic    memReq,
    input  logic    memAck,
    output logic    memWrite,
    output dataWord memAddr,
    output dataWord memWdata,
    input  dataWord memRdata
);

    logic    dispatch;
    logic    unitIdle;
    minorOp  curOp;
    dataWord curAddr;
    dataWord curData;
    regAddr  curReg;
    logic    fixedStart;
    logic    ioStart;
    logic    cacheStart;
    logic    badOpDone;
    logic    fixedDone;
    logic    ioDone;
    logic    cacheDone;
    dataWord fixedData;
    dataWord ioData;
    dataWord cacheData;

    lsuAddressDecode u_addressDecode (.*);

    // ********************
    // memory targets
    // ********************
    fixedMemory u_fixedMemory (
        .clk   (clk),
        .clkEn (clkEn),
        .rstN  (rstN),
        .start (fixedStart),
        .op    (curOp),
        .addr  (curAddr),
        .wdata (curData),
        .done  (fixedDone),
        .rdata (fixedData)
    );

    ioRegisterBank u_ioRegisterBank (
        .clk    (clk),
        .clkEn  (clkEn),
        .rstN   (rstN),
        .start  (ioStart),
        .op     (curOp),
        .addr   (curAddr),
        .wdata  (curData),
        .done   (ioDone),
        .rdata  (ioData),
        .ioPins (ioPins)
    );

    directMappedCache u_cache (
        .clk      (clk),
        .clkEn    (clkEn),
        .rstN     (rstN),
        .start    (cacheStart),
        .op       (curOp),
        .addr     (curAddr),
        .wdata    (curData),
        .done     (cacheDone),
        .rdata    (cacheData),
        .memReq   (memReq),
        .memAck   (memAck),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memRdata (memRdata)
    );

    lsuResultWriteback u_resultWriteback (.*);

endmodule

`default_nettype wire

/* hdl/lsuResultWriteback.sv */
`timescale 1ns/100ps
`default_nettype none

module lsuResultWriteback
    import lsuPkg::*;
(
    input  logic    clk,
    input  logic    clkEn,
    input  logic    rstN,
    input  logic    req,
    input  logic    dispatch,
    input  minorOp  curOp,
    input  regAddr  curReg,
    input  logic    fixedDone,
    input  logic    ioDone,
    input  logic    cacheDone,
    input  logic    badOpDone,
    input  dataWord fixedData,
    input  dataWord ioData,
    input  dataWord cacheData,
    output logic    unitIdle,
    output logic    ack,
    output logic    error,
    output dataWord loadData,
    output logic    wbValid,
    output regAddr  wbReg,
    output dataWord wbData
);

    typedef enum logic [1:0] {
        idle,
        busy,
        acked
    } wbState;

    wbState  state;
    logic    anyDone;
    logic    writesReg;
    dataWord doneData;

    assign anyDone   = fixedDone || ioDone || cacheDone || badOpDone;
    assign writesReg = (curOp == OpLoad) || (curOp == OpSwap);

    always_comb begin
        doneData = fixedData;
        if (ioDone) begin
            doneData = ioData;
        end else if (cacheDone) begin
            doneData = cacheData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= idle;
            wbValid <= 1'b0;
            error   <= 1'b0;
        end else if (clkEn) begin
            wbValid <= 1'b0; // one cycle pulse alongside the rising ack
            case (state)
                idle: begin
                    if (dispatch) state <= busy;
                end
                busy: begin
                    if (anyDone) begin
                        state   <= acked;
                        error   <= badOpDone;
                        wbValid <= writesReg && !badOpDone;
                    end
                end
                acked: begin
                    if (!req) state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn && state == busy && anyDone) begin
            loadData <= doneData;
            wbReg    <= curReg;
            wbData   <= doneData;
        end
    end

    assign ack      = state == acked;
    assign unitIdle = state == idle;

    holdAck: assert property (@(posedge clk) disable iff (!rstN)
        ack && req |=> ack);

endmodule

`default_nettype wire

/* hdl/directMappedCache.sv */
`timescale 1ns/100ps
`default_nettype none

module directMappedCache
    import lsuPkg::*;
(
    input  logic    clk,
    input  logic    clkEn,
    input  logic    rstN,
    input  logic    start,
    input  minorOp  op,
    input  dataWord addr,
    input  dataWord wdata,
    output logic    done,
    output dataWord rdata,
    output logic    memReq,
    input  logic    memAck,
    output logic    memWrite,
    output dataWord memAddr,
    output dataWord memWdata,
    input  dataWord memRdata
);

    typedef enum logic [2:0] {
        idle,
        lookup,
        fetch,
        fetchRelease,
        write,
        writeRelease,
        finish
    } cacheState;

    cacheState                  state;
    logic                       lineValid [CacheLines];
    logic [CacheTagWidth-1:0]   lineTag [CacheLines];
    dataWord                    lineData [CacheLines];
    dataWord                    oldValue;
    logic [CacheIndexWidth-1:0] index;
    logic [CacheTagWidth-1:0]   tag;
    logic                       hit;

    assign index = addr[CacheIndexWidth-1:0];
    assign tag   = addr[DataWidth-1:CacheIndexWidth];
    assign hit   = lineValid[index] && (lineTag[index] == tag);

    // ********************
    // control
    // ********************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= idle;
            for (int i = 0; i < CacheLines; i++) begin
                lineValid[i] <= 1'b0;
            end
        end else if (clkEn) begin
            case (state)
                idle: begin
                    if (start) state <= lookup;
                end
                lookup: begin
                    if (op == OpStore) begin
                        state <= write; // no allocate, so a store never fetches
                    end else if (!hit) begin
                        state <= fetch;
                    end else if (op == OpSwap) begin
                        state <= write;
                    end else begin
                        state <= idle; // load hit is answered right here
                    end
                end
                fetch: begin
                    if (memAck) begin
                        lineValid[index] <= 1'b1;
                        state            <= fetchRelease;
                    end
                end
                fetchRelease: begin
                    if (!memAck) state <= (op == OpSwap) ? write : finish;
                end
                write: begin
                    if (memAck) state <= writeRelease;
                end
                writeRelease: begin
                    if (!memAck) state <= finish;
                end
                default: state <= idle;
            endcase
        end
    end

    // ********************
    // line storage
    // ********************
    always_ff @(posedge clk) begin
        if (clkEn) begin
            if (state == lookup && hit) begin
                oldValue <= lineData[index];
            end
            if (state == fetch && memAck) begin
                lineTag[index]  <= tag;
                lineData[index] <= memRdata;
                oldValue        <= memRdata;
            end
            // after a swap fill the line hits here as well
            if (state == write && memAck && hit) begin
                lineData[index] <= wdata;
            end
        end
    end

    assign done  = ((state == lookup) && (op == OpLoad) && hit) || (state == finish);
    assign rdata = (state == lookup) ? lineData[index] : oldValue;

    assign memReq   = (state == fetch) || (state == write);
    assign memWrite = state == write;
    assign memAddr  = addr;
    assign memWdata = wdata;

    startInIdle: assert property (@(posedge clk) disable iff (!rstN)
        start |-> state == idle);

    // backing memory handshake is four phase
    holdMemReq: assert property (@(posedge clk) disable iff (!rstN)
        memReq && !memAck |=> memReq);

endmodule

`default_nettype wire

/* hdl/ioRegisterBank.sv */
`timescale 1ns/100ps
`default_nettype none

module ioRegisterBank
    import lsuPkg::*;
(
    input  logic    clk,
    input  logic    clkEn,
    input  logic    rstN,
    input  logic    start,
    input  minorOp  op,
    input  dataWord addr,
    input  dataWord wdata,
    output logic    done,
    output dataWord rdata,
    output dataWord ioPins
);

    dataWord                 ioReg [IoRegCount];
    logic [IoIndexWidth-1:0] index;
    logic                    writes;

    // only the low bits select a register, so the window repeats
    assign index  = addr[IoIndexWidth-1:0];
    assign writes = (op == OpStore) || (op == OpSwap);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < IoRegCount; i++) begin
                ioReg[i] <= '0;
            end
            done <= 1'b0;
        end else if (clkEn) begin
            done <= start;
            if (start && writes) begin
                ioReg[index] <= wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn && start) begin
            rdata <= ioReg[index]; // old value for load and swap
        end
    end

    assign ioPins = ioReg[0];

endmodule

`default_nettype wire

/* hdl/fixedMemory.sv */
`timescale 1ns/100ps
`default_nettype none

module fixedMemory
    import lsuPkg::*;
(
    input  logic    clk,
    input  logic    clkEn,
    input  logic    rstN,
    input  logic    start,
    input  minorOp  op,
    input  dataWord addr,
    input  dataWord wdata,
    output logic    done,
    output dataWord rdata
);

    dataWord                    mem [FixedDepth];
    logic [FixedIndexWidth-1:0] index;
    logic                       writes;

    assign index  = addr[FixedIndexWidth-1:0];
    assign writes = (op == OpStore) || (op == OpSwap);

    // read happens before the write so swap sees the old word
    always_ff @(posedge clk) begin
        if (clkEn && start) begin
            rdata <= mem[index];
            if (writes) begin
                mem[index] <= wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            done <= 1'b0;
        end else if (clkEn) begin
            done <= start; // fixed single cycle latency
        end
    end

endmodule

`default_nettype wire

/* hdl/lsuAddressDecode.sv */
`timescale 1ns/100ps
`default_nettype none

module lsuAddressDecode
    import lsuPkg::*;
(
    input  logic    clk,
    input  logic    clkEn,
    input  logic    rstN,
    input  logic    req,
    input  minorOp  op,
    input  dataWord addr,
    input  dataWord storeData,
    input  regAddr  destReg,
    input  logic    unitIdle,
    output logic    dispatch,
    output minorOp  curOp,
    output dataWord curAddr,
    output dataWord curData,
    output regAddr  curReg,
    output logic    fixedStart,
    output logic    ioStart,
    output logic    cacheStart,
    output logic    badOpDone
);

    logic   inCache;
    logic   inIo;
    portSel regionSel;
    portSel curPort;
    logic   pending;
    logic   opValid;

    assign dispatch = req && unitIdle;

    assign inCache = addr >= CacheBase;
    assign inIo    = (addr >= IoBase) && (addr <= IoLimit);

    always_comb begin
        case ({inCache, inIo})
            2'b01:   regionSel = PortIo;
            2'b10:   regionSel = PortCache;
            default: regionSel = PortFixed; // both set cannot happen, fixed memory takes it
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pending <= 1'b0;
        end else if (clkEn) begin
            pending <= dispatch; // start goes out the cycle after capture
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn && dispatch) begin
            curOp   <= op;
            curAddr <= addr;
            curData <= storeData;
            curReg  <= destReg;
            curPort <= regionSel;
        end
    end

    assign opValid = (curOp == OpLoad) || (curOp == OpStore) || (curOp == OpSwap);

    assign fixedStart = pending && opValid && (curPort == PortFixed);
    assign ioStart    = pending && opValid && (curPort == PortIo);
    assign cacheStart = pending && opValid && (curPort == PortCache);
    assign badOpDone  = pending && !opValid;

    // ********************
    // checks
    // ********************
    oneStart: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({fixedStart, ioStart, cacheStart, badOpDone}));

    // writeback must leave idle once an operation is taken
    noDoubleCapture: assert property (@(posedge clk) disable iff (!rstN)
        clkEn && dispatch |=> !dispatch);

endmodule

`default_nettype wire

/* hdl/lsuPkg.sv */
`default_nettype none

package lsuPkg;

    // ********************
    // widths
    // ********************
    localparam int DataWidth    = 16;
    localparam int RegAddrWidth = 4;

    typedef logic [DataWidth-1:0]    dataWord;
    typedef logic [RegAddrWidth-1:0] regAddr;
    typedef logic [3:0]              minorOp;

    localparam minorOp OpLoad  = 4'd0;
    localparam minorOp OpStore = 4'd1;
    localparam minorOp OpSwap  = 4'd2; // old value comes back, new value goes in

    // ********************
    // address map
    // ********************
    localparam dataWord IoBase    = 16'd384;
    localparam dataWord IoLimit   = 16'd511;
    localparam dataWord CacheBase = 16'd1024; // everything above goes through the cache

    localparam int FixedDepth      = 1024;
    localparam int FixedIndexWidth = $clog2(FixedDepth);
    localparam int IoRegCount      = 16;
    localparam int IoIndexWidth    = $clog2(IoRegCount);
    localparam int CacheLines      = 16;
    localparam int CacheIndexWidth = $clog2(CacheLines);
    localparam int CacheTagWidth   = DataWidth - CacheIndexWidth;

    typedef logic [1:0] portSel;

    localparam portSel PortFixed = 2'd0;
    localparam portSel PortIo    = 2'd1;
    localparam portSel PortCache = 2'd2;

endpackage

`default_nettype wire
